// ==== common/psrPkg.sv ====
package psrPkg;

  // Register and field sizes
  localparam int psrWidth      = 32;
  localparam int modeWidth     = 5;
  localparam int fieldCount    = 4;   // MSR byte lanes c, x, s, f
  localparam int flagsWidth    = 4;
  localparam int excCount      = 6;
  localparam int excIndexWidth = 3;
  localparam int bankCount     = 5;
  localparam int bankWidth     = 3;

  // Processor modes
  localparam logic [modeWidth-1:0] modeUser       = 5'b10000;
  localparam logic [modeWidth-1:0] modeFiq        = 5'b10001;
  localparam logic [modeWidth-1:0] modeIrq        = 5'b10010;
  localparam logic [modeWidth-1:0] modeSupervisor = 5'b10011;
  localparam logic [modeWidth-1:0] modeAbort      = 5'b10111;
  localparam logic [modeWidth-1:0] modeUndefined  = 5'b11011;
  localparam logic [modeWidth-1:0] modeSystem     = 5'b11111;

  // PSR bit positions
  localparam int flagsMsb      = 31;  // N
  localparam int flagsLsb      = 28;  // V
  localparam int endianBit     = 9;
  localparam int irqDisableBit = 7;
  localparam int fiqDisableBit = 6;

  // Supervisor with I, F and E set, i.e. 0x000002D3
  localparam logic [psrWidth-1:0] psrResetValue =
    (psrWidth'(1) << endianBit) | (psrWidth'(1) << irqDisableBit) |
    (psrWidth'(1) << fiqDisableBit) | psrWidth'(modeSupervisor);

  // Bit positions in the request vector
  localparam logic [excIndexWidth-1:0] excFiq           = 3'd0;
  localparam logic [excIndexWidth-1:0] excIrq           = 3'd1;
  localparam logic [excIndexWidth-1:0] excDataAbort     = 3'd2;
  localparam logic [excIndexWidth-1:0] excPrefetchAbort = 3'd3;
  localparam logic [excIndexWidth-1:0] excSoftware      = 3'd4;
  localparam logic [excIndexWidth-1:0] excUndefined     = 3'd5;

  // Exception vectors
  localparam logic [psrWidth-1:0] vectorUndefined     = 32'h0000_0004;
  localparam logic [psrWidth-1:0] vectorSoftware      = 32'h0000_0008;
  localparam logic [psrWidth-1:0] vectorPrefetchAbort = 32'h0000_000C;
  localparam logic [psrWidth-1:0] vectorDataAbort     = 32'h0000_0010;
  localparam logic [psrWidth-1:0] vectorIrq           = 32'h0000_0018;
  localparam logic [psrWidth-1:0] vectorFiq           = 32'h0000_001C;

  // SPSR banks
  localparam logic [bankWidth-1:0] bankSupervisor = 3'd0;
  localparam logic [bankWidth-1:0] bankAbort      = 3'd1;
  localparam logic [bankWidth-1:0] bankUndefined  = 3'd2;
  localparam logic [bankWidth-1:0] bankIrq        = 3'd3;
  localparam logic [bankWidth-1:0] bankFiq        = 3'd4;

endpackage

// ==== common/wbRegPkg.sv ====
package wbRegPkg;

  // Wishbone port sizes
  localparam int wbDataWidth = 32;
  localparam int wbAddrWidth = 5;
  localparam int wbSelWidth  = wbDataWidth / 8;

  // Timer reload register
  localparam int timerWidth = 16;

  // Byte addresses of the register map
  localparam logic [wbAddrWidth-1:0] regCpsr       = 5'h00;  // MSR to CPSR, read CPSR
  localparam logic [wbAddrWidth-1:0] regSpsr       = 5'h04;  // MSR to SPSR, read SPSR
  localparam logic [wbAddrWidth-1:0] regExcRequest = 5'h08;  // Raise requests, read pending
  localparam logic [wbAddrWidth-1:0] regRestore    = 5'h0C;  // Any write returns from exception
  localparam logic [wbAddrWidth-1:0] regTimerLoad  = 5'h10;
  localparam logic [wbAddrWidth-1:0] regTimerCtrl  = 5'h14;  // Bit 0 enables
  localparam logic [wbAddrWidth-1:0] regVector     = 5'h18;  // Read only
  localparam logic [wbAddrWidth-1:0] regFlags      = 5'h1C;  // NZCV in bits 31:28

endpackage

// ==== statusRegisters/statusRegisters.sv ====
`timescale 1ns/1ps

module statusRegisters (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               msrWrite,
  input  logic                               msrSpsr,        // R bit
  input  logic [psrPkg::fieldCount-1:0]      msrMask,        // One bit per byte lane
  input  logic [psrPkg::psrWidth-1:0]        msrData,
  input  logic                               flagsWrite,
  input  logic [psrPkg::flagsWidth-1:0]      flagsData,
  input  logic                               restore,
  input  logic                               enterException,
  input  logic [psrPkg::excIndexWidth-1:0]   enterIndex,
  output logic [psrPkg::psrWidth-1:0]        cpsr,
  output logic [psrPkg::psrWidth-1:0]        spsr
);
  import psrPkg::*;

  logic [psrWidth-1:0]  spsrBank [bankCount];
  logic [modeWidth-1:0] currentMode;
  logic [bankWidth-1:0] currentBank;
  logic                 hasSpsr;       // False in user and system
  logic                 privileged;
  logic                 legalMode;
  logic [psrWidth-1:0]  msrBase;
  logic [psrWidth-1:0]  msrResult;
  logic [modeWidth-1:0] entryMode;
  logic [bankWidth-1:0] entryBank;
  logic                 entryFiq;

  assign currentMode = cpsr[modeWidth-1:0];
  assign privileged  = currentMode != modeUser;

  // Bank of the current mode
  always_comb begin
    hasSpsr     = 1'b1;
    currentBank = bankSupervisor;
    case (currentMode)
      modeFiq:        currentBank = bankFiq;
      modeIrq:        currentBank = bankIrq;
      modeSupervisor: currentBank = bankSupervisor;
      modeAbort:      currentBank = bankAbort;
      modeUndefined:  currentBank = bankUndefined;
      default:        hasSpsr     = 1'b0;  // User, system or junk
    endcase
  end

  assign spsr = hasSpsr ? spsrBank[currentBank] : cpsr;  // No SPSR so mirror CPSR

  // Only the seven architected modes may be written
  always_comb begin
    case (msrData[modeWidth-1:0])
      modeUser, modeFiq, modeIrq, modeSupervisor,
      modeAbort, modeUndefined, modeSystem: legalMode = 1'b1;
      default:                              legalMode = 1'b0;
    endcase
  end

  // MSR field merge onto the selected PSR
  assign msrBase = msrSpsr ? spsr : cpsr;

  always_comb begin
    msrResult = msrBase;
    for (int lane = 0; lane < fieldCount; lane++) begin
      // User mode reaches the flags byte only
      if (msrMask[lane] && (privileged || lane == fieldCount - 1))
        msrResult[lane*8 +: 8] = msrData[lane*8 +: 8];
    end
    if (!legalMode)
      msrResult[modeWidth-1:0] = msrBase[modeWidth-1:0];  // Keep old mode
  end

  // Target mode and bank of an entry
  always_comb begin
    entryMode = modeSupervisor;
    entryBank = bankSupervisor;
    case (enterIndex)
      excFiq: begin
        entryMode = modeFiq;
        entryBank = bankFiq;
      end
      excIrq: begin
        entryMode = modeIrq;
        entryBank = bankIrq;
      end
      excDataAbort, excPrefetchAbort: begin
        entryMode = modeAbort;  // Both aborts share a bank
        entryBank = bankAbort;
      end
      excUndefined: begin
        entryMode = modeUndefined;
        entryBank = bankUndefined;
      end
      default: begin
        entryMode = modeSupervisor;  // Software interrupt
        entryBank = bankSupervisor;
      end
    endcase
  end

  assign entryFiq = enterIndex == excFiq;

  always_ff @(posedge clk) begin
    if (reset) begin
      cpsr <= psrResetValue;
      for (int bank = 0; bank < bankCount; bank++)
        spsrBank[bank] <= '0;
    end else if (enterException) begin
      // Already in that mode means nothing to bank
      if (currentMode != entryMode) begin
        spsrBank[entryBank]      <= cpsr;
        cpsr[modeWidth-1:0]      <= entryMode;
        cpsr[irqDisableBit]      <= 1'b1;
        if (entryFiq)
          cpsr[fiqDisableBit]    <= 1'b1;
      end
    end else if (msrWrite) begin
      if (!msrSpsr)
        cpsr <= msrResult;
      else if (hasSpsr)
        spsrBank[currentBank] <= msrResult;  // Dropped in user and system
    end else if (restore) begin
      cpsr <= spsr;  // Exception return
    end else if (flagsWrite) begin
      cpsr[flagsMsb:flagsLsb] <= flagsData;  // NZCV only
    end
  end

endmodule

// ==== source/exceptionSequencer.sv ====
`timescale 1ns/1ps

module exceptionSequencer (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               excRequestWrite,
  input  logic [psrPkg::excCount-1:0]        excRequestBits,
  input  logic                               tick,
  input  logic [psrPkg::psrWidth-1:0]        cpsr,
  output logic                               enterException,
  output logic [psrPkg::excIndexWidth-1:0]   enterIndex,
  output logic                               exceptionTaken,
  output logic [psrPkg::psrWidth-1:0]        vectorAddress,
  output logic [psrPkg::excCount-1:0]        pendingBits
);
  import psrPkg::*;

  typedef enum logic [1:0] {IDLE, ENTER, VECTOR} seqState;

  seqState                  state;
  logic [excCount-1:0]      pending;
  logic [excCount-1:0]      setBits;
  logic [excCount-1:0]      clearBits;
  logic [excCount-1:0]      unmasked;
  logic [excIndexWidth-1:0] pickIndex;
  logic                     pickValid;
  logic [excIndexWidth-1:0] chosenIndex;
  logic [psrWidth-1:0]      vectorNext;

  // New requests from the host and the timer
  always_comb begin
    setBits = '0;
    if (excRequestWrite)
      setBits = excRequestBits;
    if (tick)
      setBits[excIrq] = 1'b1;
  end

  always_comb begin
    clearBits = '0;
    if (state == ENTER)
      clearBits[chosenIndex] = 1'b1;  // Served bit drops as entry fires
  end

  // I and F gate their own lines, the rest always go
  always_comb begin
    unmasked         = pending;
    unmasked[excIrq] = pending[excIrq] & ~cpsr[irqDisableBit];
    unmasked[excFiq] = pending[excFiq] & ~cpsr[fiqDisableBit];
  end

  // Fixed priority pick
  always_comb begin
    pickValid = 1'b1;
    if (unmasked[excDataAbort])          pickIndex = excDataAbort;
    else if (unmasked[excFiq])           pickIndex = excFiq;
    else if (unmasked[excIrq])           pickIndex = excIrq;
    else if (unmasked[excPrefetchAbort]) pickIndex = excPrefetchAbort;
    else if (unmasked[excUndefined])     pickIndex = excUndefined;
    else if (unmasked[excSoftware])      pickIndex = excSoftware;
    else begin
      pickValid = 1'b0;
      pickIndex = excFiq;
    end
  end

  always_comb begin
    case (chosenIndex)
      excFiq:           vectorNext = vectorFiq;
      excIrq:           vectorNext = vectorIrq;
      excDataAbort:     vectorNext = vectorDataAbort;
      excPrefetchAbort: vectorNext = vectorPrefetchAbort;
      excUndefined:     vectorNext = vectorUndefined;
      default:          vectorNext = vectorSoftware;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= IDLE;
      pending       <= '0;
      vectorAddress <= '0;
    end else begin
      pending <= (pending & ~clearBits) | setBits;  // Set wins over clear
      case (state)
        IDLE: if (pickValid) begin
          chosenIndex <= pickIndex;
          state       <= ENTER;
        end
        ENTER: begin
          vectorAddress <= vectorNext;  // Valid while exceptionTaken
          state         <= VECTOR;
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign enterException = state == ENTER;
  assign enterIndex     = chosenIndex;
  assign exceptionTaken = state == VECTOR;
  assign pendingBits    = pending;

endmodule

// ==== source/tickTimer.sv ====
`timescale 1ns/1ps

module tickTimer (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             loadWrite,
  input  logic [wbRegPkg::timerWidth-1:0]  loadValue,
  input  logic                             timerEnable,
  output logic                             tick
);
  import wbRegPkg::*;

  logic [timerWidth-1:0] loadReg;  // Reload value
  logic [timerWidth-1:0] count;

  // One tick every load+1 cycles while enabled
  always_ff @(posedge clk) begin
    if (reset) begin
      loadReg <= '0;
      count   <= '0;
      tick    <= 1'b0;
    end else if (loadWrite) begin
      loadReg <= loadValue;
      count   <= loadValue;  // Restart the period
      tick    <= 1'b0;
    end else if (timerEnable) begin
      if (count == '0) begin
        count <= loadReg;
        tick  <= 1'b1;
      end else begin
        count <= count - 1'b1;
        tick  <= 1'b0;
      end
    end else begin
      tick <= 1'b0;  // Paused, count holds
    end
  end

endmodule

// ==== source/wbRegisterPort.sv ====
`timescale 1ns/1ps

module wbRegisterPort (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              cyc,
  input  logic                              stb,
  input  logic                              we,
  input  logic [wbRegPkg::wbAddrWidth-1:0]  adr,
  input  logic [wbRegPkg::wbSelWidth-1:0]   sel,
  input  logic [wbRegPkg::wbDataWidth-1:0]  datIn,
  input  logic [psrPkg::psrWidth-1:0]       cpsr,
  input  logic [psrPkg::psrWidth-1:0]       spsr,
  input  logic [psrPkg::excCount-1:0]       pendingBits,
  input  logic [psrPkg::psrWidth-1:0]       vectorAddress,
  output logic [wbRegPkg::wbDataWidth-1:0]  datOut,
  output logic                              ack,
  output logic                              msrWrite,
  output logic                              msrSpsr,
  output logic [psrPkg::fieldCount-1:0]     msrMask,
  output logic [psrPkg::psrWidth-1:0]       msrData,
  output logic                              flagsWrite,
  output logic [psrPkg::flagsWidth-1:0]     flagsData,
  output logic                              restore,
  output logic                              excRequestWrite,
  output logic [psrPkg::excCount-1:0]       excRequestBits,
  output logic                              loadWrite,
  output logic [wbRegPkg::timerWidth-1:0]   loadValue,
  output logic                              timerEnable
);
  import psrPkg::*;
  import wbRegPkg::*;

  logic                   access;       // First cycle of a strobe
  logic                   writeAccess;
  logic [wbDataWidth-1:0] readMux;

  assign access      = cyc & stb & ~ack;  // Blocks a back-to-back ack
  assign writeAccess = access & we;

  // Command pulses land on the edge that raises ack
  assign msrWrite        = writeAccess & (adr == regCpsr || adr == regSpsr);
  assign msrSpsr         = adr == regSpsr;
  assign msrMask         = sel;  // Byte selects are the field mask
  assign msrData         = datIn;
  assign flagsWrite      = writeAccess & (adr == regFlags);
  assign flagsData       = datIn[flagsMsb:flagsLsb];
  assign restore         = writeAccess & (adr == regRestore);
  assign excRequestWrite = writeAccess & (adr == regExcRequest);
  assign excRequestBits  = datIn[excCount-1:0];
  assign loadWrite       = writeAccess & (adr == regTimerLoad);
  assign loadValue       = datIn[timerWidth-1:0];

  // Readback
  always_comb begin
    readMux = '0;
    case (adr)
      regCpsr:       readMux = cpsr;
      regSpsr:       readMux = spsr;
      regExcRequest: readMux = wbDataWidth'(pendingBits);
      regTimerCtrl:  readMux = wbDataWidth'(timerEnable);
      regVector:     readMux = vectorAddress;
      regFlags:      readMux[flagsMsb:flagsLsb] = cpsr[flagsMsb:flagsLsb];
      default:       readMux = '0;  // Restore and timer load are write only
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ack         <= 1'b0;
      timerEnable <= 1'b0;
    end else begin
      ack <= access;
      if (writeAccess && adr == regTimerCtrl)
        timerEnable <= datIn[0];
    end
  end

  always_ff @(posedge clk) begin
    if (access && !we)
      datOut <= readMux;  // Held through the ack cycle
  end

endmodule

// ==== source/statusUnit.sv ====
`timescale 1ns/1ps

module statusUnit (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              cyc,
  input  logic                              stb,
  input  logic                              we,
  input  logic [wbRegPkg::wbAddrWidth-1:0]  adr,
  input  logic [wbRegPkg::wbSelWidth-1:0]   sel,
  input  logic [wbRegPkg::wbDataWidth-1:0]  datIn,
  output logic [wbRegPkg::wbDataWidth-1:0]  datOut,
  output logic                              ack,
  output logic                              exceptionTaken
);
  import psrPkg::*;
  import wbRegPkg::*;

  // Host commands
  logic                    msrWrite;
  logic                    msrSpsr;
  logic [fieldCount-1:0]   msrMask;
  logic [psrWidth-1:0]     msrData;
  logic                    flagsWrite;
  logic [flagsWidth-1:0]   flagsData;
  logic                    restore;
  logic                    excRequestWrite;
  logic [excCount-1:0]     excRequestBits;
  logic                    loadWrite;
  logic [timerWidth-1:0]   loadValue;
  logic                    timerEnable;

  // Status and entry
  logic [psrWidth-1:0]      cpsr;
  logic [psrWidth-1:0]      spsr;
  logic [excCount-1:0]      pendingBits;
  logic [psrWidth-1:0]      vectorAddress;
  logic                     enterException;
  logic [excIndexWidth-1:0] enterIndex;
  logic                     tick;

  wbRegisterPort u_port (
    .clk, .reset, .cyc, .stb, .we, .adr, .sel, .datIn,
    .cpsr, .spsr, .pendingBits, .vectorAddress,
    .datOut, .ack,
    .msrWrite, .msrSpsr, .msrMask, .msrData,
    .flagsWrite, .flagsData, .restore,
    .excRequestWrite, .excRequestBits,
    .loadWrite, .loadValue, .timerEnable
  );

  statusRegisters u_psr (
    .clk, .reset,
    .msrWrite, .msrSpsr, .msrMask, .msrData,
    .flagsWrite, .flagsData, .restore,
    .enterException, .enterIndex,
    .cpsr, .spsr
  );

  exceptionSequencer u_seq (
    .clk, .reset,
    .excRequestWrite, .excRequestBits, .tick, .cpsr,
    .enterException, .enterIndex, .exceptionTaken,
    .vectorAddress, .pendingBits
  );

  tickTimer u_timer (
    .clk, .reset, .loadWrite, .loadValue, .timerEnable,
    .tick  // Feeds the IRQ latch
  );

endmodule

// ==== testbench/statusUnit_asserts.sv ====
`timescale 1ns/1ps

module statusUnit_asserts (
  input logic clk,
  input logic reset,
  input logic cyc,
  input logic stb,
  input logic ack,
  input logic enterException,
  input logic exceptionTaken
);

  // Ack only answers a live strobe
  ackNeedsStrobe: assert property (@(posedge clk) disable iff (reset) ack |-> (cyc && stb))
    else $error("ack raised without cyc and stb");

  // Slow stb drop must not retrigger ack
  ackSingleCycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
    else $error("ack high for two cycles in a row");

  // ENTER is always followed by VECTOR
  takenAfterEnter: assert property (
    @(posedge clk) disable iff (reset) enterException |=> exceptionTaken)
    else $error("exceptionTaken did not follow enterException");

  // Clean bus after reset
  ackLowAfterReset: assert property (@(posedge clk) reset |=> !ack)
    else $error("ack high right after reset");

endmodule

bind statusUnit statusUnit_asserts u_asserts (
  .clk(clk),
  .reset(reset),
  .cyc(cyc),
  .stb(stb),
  .ack(ack),
  .enterException(enterException),
  .exceptionTaken(exceptionTaken)
);

// ==== testbench/statusUnitTb.sv ====
`timescale 1ns/1ps

module statusUnitTb;
  import wbRegPkg::*;

  localparam int ackTimeout      = 20;   // Cycles per bus access
  localparam int pollLimit       = 50;   // Reads per poll line
  localparam int expectedEntries = 5;    // Software, abort, undefined, two IRQs

  logic                   clk;
  logic                   reset;
  logic                   cyc;
  logic                   stb;
  logic                   we;
  logic [wbAddrWidth-1:0] adr;
  logic [wbSelWidth-1:0]  sel;
  logic [wbDataWidth-1:0] datIn;
  logic [wbDataWidth-1:0] datOut;
  logic                   ack;
  logic                   exceptionTaken;
  int                     checkCount;
  int                     errorCount;
  int                     entryCount;

  statusUnit u_dut (
    .clk, .reset, .cyc, .stb, .we, .adr, .sel, .datIn,
    .datOut, .ack, .exceptionTaken
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Count completed entries
  always @(negedge clk) begin
    if (!reset && exceptionTaken)
      entryCount++;
  end

  task automatic stopOnTimeout(input int step);
    $display("Timeout at step %0d: the DUT never acknowledged the bus access", step);
    $display("Checks: %0d, errors: %0d, entries: %0d", checkCount, errorCount, entryCount);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  // One classic cycle held until ack
  task automatic busAccess(input int step, input logic write, input logic [wbAddrWidth-1:0] addr,
                           input logic [wbSelWidth-1:0] mask, input logic [wbDataWidth-1:0] data,
                           output logic [wbDataWidth-1:0] readData);
    int waitCycles;
    waitCycles = 0;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= write;
    adr   <= addr;
    sel   <= mask;
    datIn <= data;
    do begin
      @(negedge clk);  // Away from the edge that moves ack
      waitCycles++;
    end while (!ack && waitCycles < ackTimeout);
    if (!ack) begin
      stopOnTimeout(step);
    end else begin
      readData = datOut;  // Registered, stable during ack
      @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
    end
  endtask

  // Plain read or a poll until the value shows up
  task automatic checkRead(input int step, input logic [wbAddrWidth-1:0] addr,
                           input logic [wbDataWidth-1:0] expected, input logic poll);
    logic [wbDataWidth-1:0] value;
    int                     tries;
    tries = 0;
    busAccess(step, 1'b0, addr, '1, '0, value);
    while (poll && value !== expected && tries < pollLimit) begin
      busAccess(step, 1'b0, addr, '1, '0, value);
      tries++;
    end
    checkCount++;
    assert (value === expected) else begin
      errorCount++;
      $display("ERROR step %0d %s 0x%02h: expected 0x%08h, actual 0x%08h",
               step, poll ? "poll" : "read", addr, expected, value);
    end
  endtask

  task automatic replayScript();
    int                     fd;
    int                     step;
    string                  lineBuf;
    logic [3:0]             op;
    logic [wbAddrWidth-1:0] addr;
    logic [wbSelWidth-1:0]  mask;
    logic [wbDataWidth-1:0] data;
    logic [wbDataWidth-1:0] expected;
    logic [wbDataWidth-1:0] unused;
    step = 0;
    fd = $fopen("testbench/statusUnit_golden.txt", "r");
    if (fd == 0) begin
      errorCount++;
      $display("Could not open the golden file testbench/statusUnit_golden.txt");
    end else begin
      while ($fgets(lineBuf, fd) != 0) begin
        // Header and blank lines do not scan
        if ($sscanf(lineBuf, "%h %h %h %h %h", op, addr, mask, data, expected) == 5) begin
          step++;
          if (op == 4'h0)
            busAccess(step, 1'b1, addr, mask, data, unused);
          else
            checkRead(step, addr, expected, op == 4'h2);
        end
      end
      $fclose(fd);
      if (step == 0) begin
        errorCount++;
        $display("The golden file held no operations");
      end
    end
  endtask

  initial begin
    reset      = 1'b1;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = '0;
    sel        = '0;
    datIn      = '0;
    checkCount = 0;
    errorCount = 0;
    entryCount = 0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    replayScript();
    checkCount++;
    assert (entryCount == expectedEntries) else begin
      errorCount++;
      $display("ERROR entry count: expected %0d, actual %0d", expectedEntries, entryCount);
    end
    $display("Checks: %0d, errors: %0d, entries: %0d", checkCount, errorCount, entryCount);
    if (errorCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
common/psrPkg.sv
common/wbRegPkg.sv
statusRegisters/statusRegisters.sv
source/exceptionSequencer.sv
source/tickTimer.sv
source/wbRegisterPort.sv
source/statusUnit.sv
testbench/statusUnit_asserts.sv
testbench/statusUnitTb.sv

// ==== Bender.yml ====
package:
  name: status_unit

sources:
  # Packages first
  - common/psrPkg.sv
  - common/wbRegPkg.sv
  # RTL
  - statusRegisters/statusRegisters.sv
  - source/exceptionSequencer.sv
  - source/tickTimer.sv
  - source/wbRegisterPort.sv
  - source/statusUnit.sv
  # Testbench
  - target: simulation
    files:
      - testbench/statusUnit_asserts.sv
      - testbench/statusUnitTb.sv

// ==== testbench/statusUnit_golden.txt ====
# op adr sel data expected, all hex; op 0 write, 1 read, 2 poll
# reset state, then MSR fields in supervisor and user mode
1 00 f 00000000 000002d3
1 04 f 00000000 00000000
0 00 1 00000095 00000000
1 00 f 00000000 00000293
0 00 1 00000050 00000000
1 00 f 00000000 00000250
0 00 f 60123456 00000000
1 00 f 00000000 60000250
0 1c f 90000000 00000000
1 00 f 00000000 90000250
1 1c f 00000000 90000000
# software interrupt from user mode
0 08 f 00000010 00000000
2 00 f 00000000 900002d3
1 04 f 00000000 90000250
1 18 f 00000000 00000008
1 08 f 00000000 00000000
# data abort, undefined and IRQ raised together
0 08 f 00000026 00000000
2 18 f 00000000 00000004
2 08 f 00000000 00000002
1 00 f 00000000 900002db
1 04 f 00000000 900002d7
0 0c f 00000000 00000000
1 04 f 00000000 900002d3
0 0c f 00000000 00000000
1 04 f 00000000 90000250
# back to user mode, pending IRQ goes
0 0c f 00000000 00000000
2 18 f 00000000 00000018
2 08 f 00000000 00000000
1 00 f 00000000 900002d2
1 04 f 00000000 90000250
# timer IRQ from user mode
0 0c f 00000000 00000000
1 00 f 00000000 90000250
0 10 f 00000004 00000000
0 14 f 00000001 00000000
2 00 f 00000000 900002d2
0 14 f 00000000 00000000
1 18 f 00000000 00000018
1 04 f 00000000 90000250
